// ==== logic/rv_core_pkg.sv ====
package rv_core_pkg;

  ////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////
  localparam int NUM_REGS = 32;

  typedef logic [31:0] inst_t;     // one instruction word
  typedef logic [4:0]  reg_addr_t; // register index

  ////////////////////////////////////////
  // opcodes kept by this core
  ////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_32     = 7'b0111011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_LUI       = 7'b0110111
  } opcode_e;

  // word variants carry a separate flag
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB  // lui
  } alu_op_e;

  typedef enum logic {
    FWD_REG, // register file copy
    FWD_WB   // writeback result
  } fwd_sel_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_RELEASE
  } fetch_state_e;

  typedef enum logic [1:0] {
    IMM_I,
    IMM_U,
    IMM_NONE
  } imm_kind_e;

endpackage

// ==== logic/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch #(
  parameter int              XLEN     = 64,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic               i_riscv_clk,
  input  logic               i_rst_n,
  output logic               o_imem_req,
  output logic [XLEN-1:0]    o_imem_addr,
  input  logic               i_imem_ack,
  input  rv_core_pkg::inst_t i_imem_inst,
  output rv_core_pkg::inst_t o_inst_d,
  output logic               o_valid_d
);

  rv_core_pkg::fetch_state_e state_q;
  logic [XLEN-1:0]           pc_q;
  logic                      capture;

  // ack seen while requesting
  assign capture     = (state_q == rv_core_pkg::FETCH_REQ) && i_imem_ack;
  assign o_imem_req  = (state_q == rv_core_pkg::FETCH_REQ);
  assign o_imem_addr = pc_q;

  ////////////////////////////////////////
  // four-phase handshake FSM
  ////////////////////////////////////////
  always_ff @(posedge i_riscv_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q   <= rv_core_pkg::FETCH_IDLE;
      pc_q      <= RESET_PC;
      o_valid_d <= 1'b0;
    end else begin
      o_valid_d <= capture;  // one cycle per capture
      case (state_q)
        rv_core_pkg::FETCH_IDLE: begin
          if (!i_imem_ack) state_q <= rv_core_pkg::FETCH_REQ;
        end
        rv_core_pkg::FETCH_REQ: begin
          if (i_imem_ack) begin
            state_q <= rv_core_pkg::FETCH_RELEASE;
            pc_q    <= pc_q + XLEN'(4);  // no branches, always sequential
          end
        end
        rv_core_pkg::FETCH_RELEASE: begin
          // next request only once memory has let go of ack
          if (!i_imem_ack) state_q <= rv_core_pkg::FETCH_REQ;
        end
        default: state_q <= rv_core_pkg::FETCH_IDLE;
      endcase
    end
  end

  // fetch/decode instruction register
  always_ff @(posedge i_riscv_clk) begin
    if (capture) o_inst_d <= i_imem_inst;
  end

  a_req_hold: assert property (@(posedge i_riscv_clk) disable iff (!i_rst_n)
    o_imem_req && !i_imem_ack |=> o_imem_req && $stable(o_imem_addr));

  a_req_rise: assert property (@(posedge i_riscv_clk) disable iff (!i_rst_n)
    $rose(o_imem_req) |-> !i_imem_ack);

endmodule

// ==== logic/rv_control.sv ====
`timescale 1ns/1ps

module rv_control (
  input  rv_core_pkg::inst_t     i_inst_d,
  input  logic                   i_valid_d,
  input  rv_core_pkg::reg_addr_t i_rdaddr_e,
  input  logic                   i_regw_e,
  output rv_core_pkg::reg_addr_t o_rs1addr,
  output rv_core_pkg::reg_addr_t o_rs2addr,
  output rv_core_pkg::reg_addr_t o_rdaddr,
  output rv_core_pkg::alu_op_e   o_aluop,
  output logic                   o_word,
  output logic                   o_bsel,
  output rv_core_pkg::imm_kind_e o_immkind,
  output logic                   o_regw,
  output rv_core_pkg::fwd_sel_e  o_fwda,
  output rv_core_pkg::fwd_sel_e  o_fwdb
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;

  assign opcode    = i_inst_d[6:0];
  assign funct3    = i_inst_d[14:12];
  assign funct7    = i_inst_d[31:25];
  assign o_rs1addr = i_inst_d[19:15];
  assign o_rs2addr = i_inst_d[24:20];
  assign o_rdaddr  = i_inst_d[11:7];

  // alt picks sub over add and sra over srl
  function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_sel = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  alu_sel = rv_core_pkg::ALU_SLL;
      3'b010:  alu_sel = rv_core_pkg::ALU_SLT;
      3'b011:  alu_sel = rv_core_pkg::ALU_SLTU;
      3'b100:  alu_sel = rv_core_pkg::ALU_XOR;
      3'b101:  alu_sel = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  alu_sel = rv_core_pkg::ALU_OR;
      default: alu_sel = rv_core_pkg::ALU_AND;
    endcase
  endfunction

  ////////////////////////////////////////
  // instruction decoder
  ////////////////////////////////////////
  always_comb begin
    o_aluop   = rv_core_pkg::ALU_ADD;
    o_word    = 1'b0;
    o_bsel    = 1'b0;
    o_immkind = rv_core_pkg::IMM_NONE;
    legal     = 1'b0;
    case (opcode)
      rv_core_pkg::OPC_OP: begin
        o_aluop = alu_sel(funct3, funct7[5]);
        legal   = (funct7 == 7'b0000000) ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv_core_pkg::OPC_OP_IMM: begin
        o_bsel    = 1'b1;
        o_immkind = rv_core_pkg::IMM_I;
        o_aluop   = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);  // addi never subtracts
        case (funct3)
          3'b001:  legal = (i_inst_d[31:26] == 6'b000000);  // 6-bit shamt
          3'b101:  legal = (i_inst_d[31:26] == 6'b000000) || (i_inst_d[31:26] == 6'b010000);
          default: legal = 1'b1;
        endcase
      end
      rv_core_pkg::OPC_OP_32: begin
        o_word  = 1'b1;
        o_aluop = alu_sel(funct3, funct7[5]);
        case (funct3)
          3'b000, 3'b101: legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          3'b001:         legal = (funct7 == 7'b0000000);
          default:        legal = 1'b0;
        endcase
      end
      rv_core_pkg::OPC_OP_IMM_32: begin
        o_word    = 1'b1;
        o_bsel    = 1'b1;
        o_immkind = rv_core_pkg::IMM_I;
        o_aluop   = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
        case (funct3)
          3'b000:  legal = 1'b1;
          3'b001:  legal = (funct7 == 7'b0000000);
          3'b101:  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: legal = 1'b0;
        endcase
      end
      rv_core_pkg::OPC_LUI: begin
        o_aluop   = rv_core_pkg::ALU_PASSB;
        o_bsel    = 1'b1;
        o_immkind = rv_core_pkg::IMM_U;
        legal     = 1'b1;
      end
      default: legal = 1'b0;  // retires as a bubble
    endcase
  end

  assign o_regw = i_valid_d && legal && (o_rdaddr != '0);

  ////////////////////////////////////////
  // forwarding selection
  ////////////////////////////////////////
  // the execute-stage producer sits in writeback once this one reaches execute
  assign o_fwda = (i_regw_e && i_rdaddr_e == o_rs1addr) ? rv_core_pkg::FWD_WB
                                                        : rv_core_pkg::FWD_REG;
  assign o_fwdb = (i_regw_e && i_rdaddr_e == o_rs2addr) ? rv_core_pkg::FWD_WB
                                                        : rv_core_pkg::FWD_REG;

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile #(
  parameter int XLEN = 64
) (
  input  logic                   i_riscv_clk,
  input  logic                   i_rst_n,
  input  rv_core_pkg::reg_addr_t i_rs1addr,
  input  rv_core_pkg::reg_addr_t i_rs2addr,
  output logic [XLEN-1:0]        o_rs1data,
  output logic [XLEN-1:0]        o_rs2data,
  input  logic                   i_we,
  input  rv_core_pkg::reg_addr_t i_rdaddr,
  input  logic [XLEN-1:0]        i_rddata
);

  logic [XLEN-1:0] regs [rv_core_pkg::NUM_REGS];

  always_ff @(posedge i_riscv_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < rv_core_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rdaddr != '0) begin
      regs[i_rdaddr] <= i_rddata;
    end
  end

  // x0 first, then write-through
  assign o_rs1data = (i_rs1addr == '0)                ? '0       :
                     (i_we && i_rdaddr == i_rs1addr)  ? i_rddata :
                                                        regs[i_rs1addr];
  assign o_rs2data = (i_rs2addr == '0)                ? '0       :
                     (i_we && i_rdaddr == i_rs2addr)  ? i_rddata :
                                                        regs[i_rs2addr];

  // control drops x0 destinations before they reach writeback
  a_no_x0_write: assert property (@(posedge i_riscv_clk) disable iff (!i_rst_n)
    i_we |-> i_rdaddr != '0);

endmodule

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute #(
  parameter int XLEN = 64
) (
  input  logic                   i_riscv_clk,
  input  logic                   i_rst_n,
  input  rv_core_pkg::inst_t     i_inst_d,
  input  rv_core_pkg::reg_addr_t i_rdaddr,
  input  rv_core_pkg::alu_op_e   i_aluop,
  input  logic                   i_word,
  input  logic                   i_bsel,
  input  rv_core_pkg::imm_kind_e i_immkind,
  input  logic                   i_regw,
  input  rv_core_pkg::fwd_sel_e  i_fwda,
  input  rv_core_pkg::fwd_sel_e  i_fwdb,
  input  logic [XLEN-1:0]        i_rs1data,
  input  logic [XLEN-1:0]        i_rs2data,
  output rv_core_pkg::reg_addr_t o_rdaddr_e,
  output logic                   o_regw_e,
  output logic                   o_wb_valid,
  output rv_core_pkg::reg_addr_t o_wb_rdaddr,
  output logic [XLEN-1:0]        o_wb_data
);

  localparam int SHW = $clog2(XLEN);  // shift amount width at full size

  logic [XLEN-1:0]      imm_d;
  logic [XLEN-1:0]      imm_e;
  logic [XLEN-1:0]      rs1data_e;
  logic [XLEN-1:0]      rs2data_e;
  rv_core_pkg::alu_op_e aluop_e;
  logic                 word_e;
  logic                 bsel_e;
  rv_core_pkg::fwd_sel_e fwda_e;
  rv_core_pkg::fwd_sel_e fwdb_e;
  logic [XLEN-1:0]      op_a;
  logic [XLEN-1:0]      op_b;
  logic [XLEN-1:0]      res_full;
  logic [31:0]          res_w;
  logic [XLEN-1:0]      alu_res;

  ////////////////////////////////////////
  // immediate generation
  ////////////////////////////////////////
  always_comb begin
    case (i_immkind)
      rv_core_pkg::IMM_I: imm_d = XLEN'($signed(i_inst_d[31:20]));
      rv_core_pkg::IMM_U: imm_d = XLEN'($signed({i_inst_d[31:12], 12'b0}));
      default:            imm_d = '0;
    endcase
  end

  ////////////////////////////////////////
  // decode/execute register
  ////////////////////////////////////////
  always_ff @(posedge i_riscv_clk or negedge i_rst_n) begin
    if (!i_rst_n) o_regw_e <= 1'b0;
    else          o_regw_e <= i_regw;  // low for bubbles
  end

  always_ff @(posedge i_riscv_clk) begin
    o_rdaddr_e <= i_rdaddr;
    aluop_e    <= i_aluop;
    word_e     <= i_word;
    bsel_e     <= i_bsel;
    fwda_e     <= i_fwda;
    fwdb_e     <= i_fwdb;
    rs1data_e  <= i_rs1data;
    rs2data_e  <= i_rs2data;
    imm_e      <= imm_d;
  end

  // operand muxes, wb result forwards in the same cycle
  assign op_a = (fwda_e == rv_core_pkg::FWD_WB) ? o_wb_data : rs1data_e;
  assign op_b = bsel_e ? imm_e :
                (fwdb_e == rv_core_pkg::FWD_WB) ? o_wb_data : rs2data_e;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////
  always_comb begin
    case (aluop_e)
      rv_core_pkg::ALU_ADD:   res_full = op_a + op_b;
      rv_core_pkg::ALU_SUB:   res_full = op_a - op_b;
      rv_core_pkg::ALU_SLL:   res_full = op_a << op_b[SHW-1:0];
      rv_core_pkg::ALU_SLT:   res_full = XLEN'($signed(op_a) < $signed(op_b));
      rv_core_pkg::ALU_SLTU:  res_full = XLEN'(op_a < op_b);
      rv_core_pkg::ALU_XOR:   res_full = op_a ^ op_b;
      rv_core_pkg::ALU_SRL:   res_full = op_a >> op_b[SHW-1:0];
      rv_core_pkg::ALU_SRA:   res_full = $signed(op_a) >>> op_b[SHW-1:0];
      rv_core_pkg::ALU_OR:    res_full = op_a | op_b;
      rv_core_pkg::ALU_AND:   res_full = op_a & op_b;
      default:                res_full = op_b;  // lui
    endcase
  end

  // word variants, low half only
  always_comb begin
    case (aluop_e)
      rv_core_pkg::ALU_SUB: res_w = op_a[31:0] - op_b[31:0];
      rv_core_pkg::ALU_SLL: res_w = op_a[31:0] << op_b[4:0];
      rv_core_pkg::ALU_SRL: res_w = op_a[31:0] >> op_b[4:0];
      rv_core_pkg::ALU_SRA: res_w = $signed(op_a[31:0]) >>> op_b[4:0];
      default:              res_w = op_a[31:0] + op_b[31:0];
    endcase
  end

  assign alu_res = word_e ? XLEN'($signed(res_w)) : res_full;  // sign-extend words

  ////////////////////////////////////////
  // execute/writeback register
  ////////////////////////////////////////
  always_ff @(posedge i_riscv_clk or negedge i_rst_n) begin
    if (!i_rst_n) o_wb_valid <= 1'b0;
    else          o_wb_valid <= o_regw_e;
  end

  always_ff @(posedge i_riscv_clk) begin
    o_wb_rdaddr <= o_rdaddr_e;
    o_wb_data   <= alu_res;
  end

  // decoder knows nothing of XLEN, rv32 must not see word ops
  a_no_word_rv32: assert property (@(posedge i_riscv_clk) disable iff (!i_rst_n)
    o_regw_e && word_e |-> XLEN != 32);

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
  parameter int              XLEN     = 64,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic                   i_riscv_clk,
  input  logic                   i_rst_n,
  // instruction memory
  output logic                   o_imem_req,
  output logic [XLEN-1:0]        o_imem_addr,
  input  logic                   i_imem_ack,
  input  rv_core_pkg::inst_t     i_imem_inst,
  // retire port
  output logic                   o_wb_valid,
  output rv_core_pkg::reg_addr_t o_wb_rdaddr,
  output logic [XLEN-1:0]        o_wb_data
);

  ////////////////////////////////////////
  // decode stage
  ////////////////////////////////////////
  rv_core_pkg::inst_t     inst_d;
  logic                   valid_d;
  rv_core_pkg::reg_addr_t rs1addr_d;
  rv_core_pkg::reg_addr_t rs2addr_d;
  rv_core_pkg::reg_addr_t rdaddr_d;
  rv_core_pkg::alu_op_e   aluop_d;
  logic                   word_d;
  logic                   bsel_d;
  rv_core_pkg::imm_kind_e immkind_d;
  logic                   regw_d;
  rv_core_pkg::fwd_sel_e  fwda_d;
  rv_core_pkg::fwd_sel_e  fwdb_d;
  logic [XLEN-1:0]        rs1data_d;
  logic [XLEN-1:0]        rs2data_d;

  ////////////////////////////////////////
  // execute stage, back to control
  ////////////////////////////////////////
  rv_core_pkg::reg_addr_t rdaddr_e;
  logic                   regw_e;

  rv_fetch #(
    .XLEN     (XLEN),
    .RESET_PC (RESET_PC)
  ) u_rv_fetch (
    .i_riscv_clk (i_riscv_clk),
    .i_rst_n     (i_rst_n),
    .o_imem_req  (o_imem_req),
    .o_imem_addr (o_imem_addr),
    .i_imem_ack  (i_imem_ack),
    .i_imem_inst (i_imem_inst),
    .o_inst_d    (inst_d),
    .o_valid_d   (valid_d)
  );

  rv_control u_rv_control (
    .i_inst_d   (inst_d),
    .i_valid_d  (valid_d),
    .i_rdaddr_e (rdaddr_e),  // from the de register
    .i_regw_e   (regw_e),
    .o_rs1addr  (rs1addr_d),
    .o_rs2addr  (rs2addr_d),
    .o_rdaddr   (rdaddr_d),
    .o_aluop    (aluop_d),
    .o_word     (word_d),
    .o_bsel     (bsel_d),
    .o_immkind  (immkind_d),
    .o_regw     (regw_d),
    .o_fwda     (fwda_d),
    .o_fwdb     (fwdb_d)
  );

  rv_regfile #(
    .XLEN (XLEN)
  ) u_rv_regfile (
    .i_riscv_clk (i_riscv_clk),
    .i_rst_n     (i_rst_n),
    .i_rs1addr   (rs1addr_d),
    .i_rs2addr   (rs2addr_d),
    .o_rs1data   (rs1data_d),
    .o_rs2data   (rs2data_d),
    .i_we        (o_wb_valid),  // write port is the retire port
    .i_rdaddr    (o_wb_rdaddr),
    .i_rddata    (o_wb_data)
  );

  rv_execute #(
    .XLEN (XLEN)
  ) u_rv_execute (
    .i_riscv_clk (i_riscv_clk),
    .i_rst_n     (i_rst_n),
    .i_inst_d    (inst_d),
    .i_rdaddr    (rdaddr_d),
    .i_aluop     (aluop_d),
    .i_word      (word_d),
    .i_bsel      (bsel_d),
    .i_immkind   (immkind_d),
    .i_regw      (regw_d),
    .i_fwda      (fwda_d),
    .i_fwdb      (fwdb_d),
    .i_rs1data   (rs1data_d),
    .i_rs2data   (rs2data_d),
    .o_rdaddr_e  (rdaddr_e),
    .o_regw_e    (regw_e),
    .o_wb_valid  (o_wb_valid),
    .o_wb_rdaddr (o_wb_rdaddr),
    .o_wb_data   (o_wb_data)
  );

endmodule

// ==== include/rv_core_tb_checks.svh ====
`ifndef RV_CORE_TB_CHECKS_SVH
`define RV_CORE_TB_CHECKS_SVH

////////////////////////////////////////
// result counters
////////////////////////////////////////
int unsigned err_count  = 0;
int unsigned pass_count = 0;

// register index compare
task automatic check_addr(input string name,
                          input rv_core_pkg::reg_addr_t got,
                          input rv_core_pkg::reg_addr_t exp);
  if (got !== exp) begin
    err_count++;
    $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
  end else begin
    pass_count++;
  end
endtask

// data compare, XLEN from the including testbench
task automatic check_data(input string name,
                          input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
  if (got !== exp) begin
    err_count++;
    $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
  end else begin
    pass_count++;
  end
endtask

`endif

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  localparam int              XLEN       = 64;
  localparam logic [XLEN-1:0] RESET_PC   = '0;
  localparam int              PROG_WORDS = 256;
  localparam int              REQ_LIMIT  = 50;  // responder wait limit in cycles

  logic                   clk;
  logic                   rst_n;
  logic                   imem_req;
  logic [XLEN-1:0]        imem_addr;
  logic                   imem_ack;
  rv_core_pkg::inst_t     imem_inst;
  logic                   wb_valid;
  rv_core_pkg::reg_addr_t wb_rdaddr;
  logic [XLEN-1:0]        wb_data;

  `include "rv_core_tb_checks.svh"

  rv_core_pkg::inst_t     prog [PROG_WORDS];
  int                     prog_len;
  logic [XLEN-1:0]        ref_regs [rv_core_pkg::NUM_REGS];
  rv_core_pkg::reg_addr_t exp_rd_q [$];
  logic [XLEN-1:0]        exp_val_q [$];
  int                     max_delay;  // longest ack delay
  int unsigned            hs_count;
  logic [XLEN-1:0]        next_addr;

  typedef enum {RSP_IDLE, RSP_DELAY, RSP_ACK, RSP_HOLD} rsp_state_e;
  rsp_state_e rsp_state;
  int         rsp_wait;
  int         rsp_delay;
  logic       req_q;

  rv_core #(
    .XLEN     (XLEN),
    .RESET_PC (RESET_PC)
  ) rv_core_inst (
    .i_riscv_clk (clk),
    .i_rst_n     (rst_n),
    .o_imem_req  (imem_req),
    .o_imem_addr (imem_addr),
    .i_imem_ack  (imem_ack),
    .i_imem_inst (imem_inst),
    .o_wb_valid  (wb_valid),
    .o_wb_rdaddr (wb_rdaddr),
    .o_wb_data   (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // instruction memory responder
  ////////////////////////////////////////
  function automatic rv_core_pkg::inst_t fetch_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] idx;
    idx = addr >> 2;
    if (idx < PROG_WORDS) return prog[idx];
    return {idx[24:0] ^ idx[49:25] ^ 25'(idx >> 50), 7'h00};  // opcode 0, a bubble
  endfunction

  task automatic raise_ack();
    imem_inst <= fetch_word(imem_addr);
    imem_ack  <= 1'b1;
    hs_count  <= hs_count + 1;
    rsp_wait  = 0;
    rsp_state = RSP_ACK;
  endtask

  always @(posedge clk) begin
    req_q <= imem_req;
    if (!rst_n) begin
      imem_ack  <= 1'b0;
      next_addr <= RESET_PC;
      rsp_state = RSP_IDLE;
      rsp_wait  = 0;
    end else begin
      if (imem_req && !req_q && imem_ack) begin
        err_count++;
        $display("protocol error at %0t: request raised while ack still high", $time);
      end
      case (rsp_state)
        RSP_IDLE: begin
          if (imem_req) begin
            check_data("o_imem_addr", imem_addr, next_addr);
            next_addr <= next_addr + XLEN'(4);  // steps by 4
            rsp_delay = $urandom_range(0, max_delay);
            if (rsp_delay == 0) raise_ack();
            else rsp_state = RSP_DELAY;
          end else begin
            rsp_wait++;
            if (rsp_wait == REQ_LIMIT) begin
              err_count++;
              $display("timeout at %0t: fetch raised no request", $time);
            end
          end
        end
        RSP_DELAY: begin
          rsp_delay--;
          if (rsp_delay == 0) raise_ack();
        end
        RSP_ACK: begin
          if (!imem_req) begin
            rsp_wait = 0;
            if ($urandom_range(0, 1) == 0) begin
              imem_ack  <= 1'b0;
              rsp_state = RSP_IDLE;
            end else begin
              rsp_state = RSP_HOLD;
            end
          end else begin
            rsp_wait++;
            if (rsp_wait == REQ_LIMIT) begin
              err_count++;
              $display("timeout at %0t: fetch kept request high after ack", $time);
            end
          end
        end
        default: begin
          imem_ack  <= 1'b0;  // second cycle of release
          rsp_state = RSP_IDLE;
        end
      endcase
    end
  end

  // retire monitor, in fetch order
  always @(posedge clk) begin
    if (rst_n && wb_valid) begin
      if (exp_rd_q.size() == 0) begin
        err_count++;
        $display("unexpected retire at %0t: x%0d <= 0x%h", $time, wb_rdaddr, wb_data);
      end else begin
        check_addr("o_wb_rdaddr", wb_rdaddr, exp_rd_q.pop_front());
        check_data("o_wb_data", wb_data, exp_val_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
    return {{(XLEN-32){v[31]}}, v};
  endfunction

  // alt picks sub and sra
  function automatic logic [XLEN-1:0] ref_result(input logic [2:0] f3, input logic alt,
      input logic word, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    logic [31:0] w;
    if (word) begin
      case (f3)
        3'b000:  w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        3'b001:  w = a[31:0] << b[4:0];
        default: begin
          if (alt) w = $signed(a[31:0]) >>> b[4:0];
          else     w = a[31:0] >> b[4:0];
        end
      endcase
      return sext32(w);
    end
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[5:0];
      3'b010:  return XLEN'($signed(a) < $signed(b));
      3'b011:  return XLEN'(a < b);
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[5:0];
        return a >> b[5:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_step(input rv_core_pkg::inst_t w);
    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    logic [XLEN-1:0]        imm;
    logic [XLEN-1:0]        val;
    logic                   writes;
    logic                   sra_i;
    rv_core_pkg::reg_addr_t rd;
    a      = ref_regs[w[19:15]];
    b      = ref_regs[w[24:20]];
    imm    = XLEN'($signed(w[31:20]));
    rd     = w[11:7];
    sra_i  = (w[14:12] == 3'b101) && w[30];
    writes = 1'b1;
    // opcode values as in the ISA manual
    case (w[6:0])
      7'b0110011: val = ref_result(w[14:12], w[30], 1'b0, a, b);
      7'b0010011: val = ref_result(w[14:12], sra_i, 1'b0, a, imm);
      7'b0111011: val = ref_result(w[14:12], w[30], 1'b1, a, b);
      7'b0011011: val = ref_result(w[14:12], sra_i, 1'b1, a, imm);
      7'b0110111: val = sext32({w[31:12], 12'h000});
      default:    writes = 1'b0;
    endcase
    if (writes && rd != 0) begin
      ref_regs[rd] = val;
      exp_rd_q.push_back(rd);
      exp_val_q.push_back(val);
    end
  endtask

  ////////////////////////////////////////
  // program building
  ////////////////////////////////////////
  task automatic emit(input rv_core_pkg::inst_t w);
    prog[prog_len] = w;
    prog_len++;
    model_step(w);
  endtask

  task automatic emit_r(input logic [6:0] opc, input logic [6:0] f7, input logic [2:0] f3,
                        input int rd, input int rs1, input int rs2);
    emit({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc});
  endtask

  task automatic emit_i(input logic [6:0] opc, input logic [2:0] f3,
                        input int rd, input int rs1, input int imm);
    emit({12'(imm), 5'(rs1), f3, 5'(rd), opc});
  endtask

  task automatic emit_lui(input int rd, input int imm20);
    emit({20'(imm20), 5'(rd), 7'(rv_core_pkg::OPC_LUI)});
  endtask

  // random 64-bit value into rd, tmp is scratch
  task automatic load_random(input int rd, input int tmp);
    emit_lui(rd, $urandom);
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b000, rd, rd, $urandom);
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b001, rd, rd, $urandom_range(0, 31));
    emit_lui(tmp, $urandom);
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b000, tmp, tmp, $urandom);
    emit_r(rv_core_pkg::OPC_OP, 7'h00, 3'b100, rd, rd, tmp);  // xor
  endtask

  ////////////////////////////////////////
  // test sequencing
  ////////////////////////////////////////
  task automatic begin_test();
    @(posedge clk);
    rst_n <= 1'b0;
    prog_len = 0;
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = {i[24:0], 7'h00};
    end
    foreach (ref_regs[i]) ref_regs[i] = '0;
    exp_rd_q.delete();
    exp_val_q.delete();
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    if (err_count == errs_before) $display("test %-12s ok", name);
    else $display("test %-12s %0d errors", name, err_count - errs_before);
  endtask

  task automatic run_test(input string name);
    int unsigned errs_before;
    int          cycles;
    int          limit;
    errs_before = err_count;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    limit  = 200 + prog_len * (max_delay + 8);
    cycles = 0;
    while (exp_rd_q.size() != 0 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_rd_q.size() != 0) begin
      err_count++;
      $display("timeout in %s: %0d writes never retired", name, exp_rd_q.size());
    end
    repeat (20) @(negedge clk);  // room for a stray retire
    report_test(name, errs_before);
  endtask

  task automatic test_fetch_start();
    int unsigned errs_before;
    int unsigned start;
    int          cycles;
    errs_before = err_count;
    begin_test();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    cycles = 0;
    while (!imem_req && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (!imem_req) begin
      err_count++;
      $display("fetch raised no request after reset");
    end else begin
      check_data("o_imem_addr", imem_addr, RESET_PC);
    end
    start  = hs_count;
    cycles = 0;
    while (hs_count - start < 8 && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (hs_count - start < 8) begin
      err_count++;
      $display("fetch completed fewer than 8 handshakes");
    end
    report_test("fetch_start", errs_before);
  endtask

  task automatic test_imm_ops();
    begin_test();
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b000, 1, 0, 1234);     // addi
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b000, 2, 1, -2000);    // goes negative
    emit_lui(3, 20'h80001);                                  // sign-extends
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b000, 3, 3, -1);
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b111, 4, 3, 12'h0f0);  // andi
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b110, 5, 2, 12'h555);  // ori
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b100, 6, 2, -1);       // xori
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b010, 7, 2, 5);        // slti
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b011, 8, 2, 5);        // sltiu
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b001, 9, 3, 40);       // slli
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b101, 10, 3, 36);      // srli
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b101, 11, 3, 12'h424); // srai
    emit_lui(12, 20'h12345);
    run_test("imm_ops");
  endtask

  task automatic test_reg_ops(input string name, input int rounds);
    begin_test();
    for (int r = 0; r < rounds; r++) begin
      load_random(1, 12);
      load_random(2, 12);
      emit_r(rv_core_pkg::OPC_OP, 7'h00, 3'b000, 3, 1, 2);     // add
      emit_r(rv_core_pkg::OPC_OP, 7'h20, 3'b000, 4, 1, 2);     // sub
      emit_r(rv_core_pkg::OPC_OP, 7'h00, 3'b010, 5, 1, 2);     // slt
      emit_r(rv_core_pkg::OPC_OP, 7'h00, 3'b011, 6, 1, 2);     // sltu
      emit_r(rv_core_pkg::OPC_OP, 7'h20, 3'b101, 7, 1, 2);     // sra
      emit_r(rv_core_pkg::OPC_OP_32, 7'h00, 3'b000, 8, 1, 2);  // addw
      emit_r(rv_core_pkg::OPC_OP_32, 7'h20, 3'b000, 9, 1, 2);  // subw
      emit_i(rv_core_pkg::OPC_OP_IMM_32, 3'b001, 10, 1, $urandom_range(0, 31));
    end
    run_test(name);
  endtask

  task automatic test_dependencies();
    begin_test();
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b000, 5, 0, 7);
    emit_r(rv_core_pkg::OPC_OP, 7'h00, 3'b000, 5, 5, 5);      // back to back
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b001, 6, 5, 3);
    emit_r(rv_core_pkg::OPC_OP, 7'h00, 3'b000, 7, 6, 5);
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b000, 8, 0, -3);
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b000, 9, 0, 100);
    emit_r(rv_core_pkg::OPC_OP, 7'h20, 3'b000, 10, 8, 9);     // x8 two back
    emit_r(rv_core_pkg::OPC_OP_32, 7'h00, 3'b000, 11, 10, 10);
    emit_r(rv_core_pkg::OPC_OP, 7'h00, 3'b111, 12, 11, 7);
    run_test("dependencies");
  endtask

  task automatic test_x0_bubbles();
    begin_test();
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b000, 0, 0, 55);        // x0 target
    emit_i(rv_core_pkg::OPC_OP_IMM, 3'b000, 1, 0, 9);
    emit_r(rv_core_pkg::OPC_OP, 7'h00, 3'b000, 0, 1, 1);
    emit(32'h0000_3083);                                      // ld x1, dropped
    emit(32'h0100_00ef);                                      // jal x1, dropped
    emit_r(rv_core_pkg::OPC_OP, 7'h00, 3'b000, 2, 0, 1);      // x1 still 9
    emit_r(rv_core_pkg::OPC_OP, 7'h00, 3'b110, 3, 0, 0);      // x0 reads zero
    run_test("x0_bubbles");
  endtask

  // hard stop if a wait loop itself misbehaves
  initial begin
    repeat (100000) @(posedge clk);
    $display("watchdog expired, run stopped");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    imem_ack  = 1'b0;
    imem_inst = '0;
    req_q     = 1'b0;
    hs_count  = 0;
    max_delay = 3;
    rsp_state = RSP_IDLE;
    void'($urandom(68));
    test_fetch_start();
    test_imm_ops();
    test_reg_ops("reg_ops", 6);
    test_dependencies();
    test_x0_bubbles();
    max_delay = 12;  // long stalls
    test_reg_ops("long_stalls", 4);
    max_delay = 3;
    $display("checks passed %0d, errors %0d", pass_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
logic/rv_core_pkg.sv
logic/rv_fetch.sv
logic/rv_control.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_core.sv
bench/rv_core_tb.sv
